// File: tb.f
+incdir+logic
+incdir+tb
logic/mem_region_pkg.sv
logic/lsu_router.sv
logic/ram_port_mux.sv
logic/data_ram.sv
logic/mem_region.sv
tb/mem_region_tb.sv

// File: tb/mem_region_tb_tasks.svh
// Memory region directed tests
`ifndef MEM_REGION_TB_TASKS_SVH
`define MEM_REGION_TB_TASKS_SVH

  function automatic logic [31:0] local_addr(input logic [11:0] offset);
    return {`MEM_LOCAL_REGION, 8'h00, offset};
  endfunction

  // little-endian byte order with byte 0 at the lowest address
  function automatic logic [31:0] model_read32(input logic [31:0] addr);
    logic [11:0] base;
    base = {addr[11:2], 2'b00};
    return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
  endfunction

  function automatic logic [63:0] model_read64(input logic [31:0] addr);
    logic [63:0] val;
    for (int i = 0; i < 8; i++)
      val[8 * i +: 8] = ref_mem[{addr[11:3], 3'b000} + i];
    return val;
  endfunction

  task automatic model_write(input logic [31:0] addr, input int nbytes, input logic [7:0] be,
                             input logic [63:0] data);
    logic [11:0] base;
    base = (nbytes == 8) ? {addr[11:3], 3'b000} : {addr[11:2], 2'b00};
    for (int i = 0; i < nbytes; i++)
    begin
      if (be[i])
        ref_mem[base + i] = data[8 * i +: 8];
    end
  endtask

  // one request with rvalid expected in the cycle after its grant
  task automatic lsu_access(input string test, input logic [31:0] addr, input logic we,
                            input lsu_be_t be, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    #1;
    while (!lsu_gnt_o)
    begin
      @(negedge clk);
      #1;
    end
    check_value({test, " ext_req"}, addr[31:20] != `MEM_LOCAL_REGION, ext_req_o);
    if (ext_req_o)
    begin
      check_value({test, " ext_addr"}, addr, ext_addr_o);
      check_value({test, " ext_we"}, we, ext_we_o);
      check_value({test, " ext_be"}, be, ext_be_o);
      check_value({test, " ext_wdata"}, wdata, ext_wdata_o);
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    #1;
    check_value({test, " rvalid"}, 1'b1, lsu_rvalid_o);
    rdata = lsu_rdata_o;
    if (we && addr[31:20] == `MEM_LOCAL_REGION)
      model_write(addr, 4, {4'h0, be}, {32'h0, wdata});
  endtask

  task automatic sys_access(input logic [31:0] addr, input logic we, input ram_be_t be,
                            input logic [63:0] data);
    @(negedge clk);
    sys_req_i   = 1'b1;
    sys_addr_i  = addr;
    sys_we_i    = we;
    sys_be_i    = be;
    sys_wdata_i = data;
    @(negedge clk);
    sys_req_i = 1'b0;
    sys_we_i  = 1'b0;
    #1;
    if (we)
      model_write(addr, 8, be, data);
  endtask

  task automatic test_reset_state();
    #1;
    check_value("reset_state rvalid", 1'b0, lsu_rvalid_o);
    check_value("reset_state ext_req", 1'b0, ext_req_o);
  endtask

  task automatic test_full_word();
    logic [31:0] rdata;
    for (int i = 0; i < 8; i++)
      lsu_access("full_word", local_addr(12'h100 + 12'(4 * i)), 1'b1, 4'hf, rand_bits(32), rdata);
    for (int i = 0; i < 8; i++)
    begin
      lsu_access("full_word", local_addr(12'h100 + 12'(4 * i)), 1'b0, 4'hf, 32'h0, rdata);
      check_value("full_word rdata", model_read32(local_addr(12'h100 + 12'(4 * i))), rdata);
    end
  endtask

  task automatic test_partial_store();
    logic [31:0] addr;
    logic [31:0] rdata;
    for (int i = 0; i < 6; i++)
    begin
      addr = local_addr(12'h200 + 12'(4 * i));
      lsu_access("partial", addr, 1'b1, 4'hf, rand_bits(32), rdata);
      lsu_access("partial", addr, 1'b1, 4'(rand_bits(4)), rand_bits(32), rdata);
      lsu_access("partial", addr, 1'b0, 4'hf, 32'h0, rdata);
      check_value("partial rdata", model_read32(addr), rdata);
    end
  endtask

  task automatic test_external();
    logic [11:0] region;
    logic [31:0] addr;
    logic [31:0] rdata;
    for (int i = 0; i < 4; i++)
    begin
      region = 12'(rand_bits(12));
      if (region == `MEM_LOCAL_REGION)
        region[11] = 1'b1;
      // same low bits as a local word written earlier
      addr = {region, 8'h00, 12'h100 + 12'(4 * i)};
      lsu_access("external", addr, 1'b1, 4'hf, rand_bits(32), rdata);
      lsu_access("external", addr, 1'b0, 4'hf, 32'h0, rdata);
      check_value("external rdata", addr ^ EXT_XOR, rdata);
      lsu_access("external", local_addr(addr[11:0]), 1'b0, 4'hf, 32'h0, rdata);
      check_value("external local", model_read32(addr), rdata);
    end
  endtask

  task automatic test_system_port();
    logic [31:0] addr;
    logic [63:0] data;
    logic [31:0] rdata;
    for (int i = 0; i < 4; i++)
    begin
      // low three bits are ignored by the system port
      addr = 32'h0000_0300 + 32'(8 * i) + rand_bits(3);
      data = {rand_bits(32), rand_bits(32)};
      sys_access(addr, 1'b1, 8'hff, data);
      lsu_access("system", local_addr({addr[11:3], 3'b000}), 1'b0, 4'hf, 32'h0, rdata);
      check_value("system lane0", data[31:0], rdata);
      lsu_access("system", local_addr({addr[11:3], 3'b100}), 1'b0, 4'hf, 32'h0, rdata);
      check_value("system lane1", data[63:32], rdata);
      lsu_access("system", local_addr({addr[11:3], 3'(4 * (i % 2))}), 1'b1, 4'b0110,
                 rand_bits(32), rdata);
      sys_access(addr, 1'b0, 8'h00, 64'h0);
      check_value("system readback", model_read64(addr), sys_rdata_o);
    end
  endtask

  task automatic test_priority();
    logic [31:0] rdata;
    @(negedge clk);
    sys_req_i   = 1'b1;
    sys_addr_i  = 32'h0000_0400;
    sys_we_i    = 1'b1;
    sys_be_i    = 8'hff;
    sys_wdata_i = {rand_bits(32), rand_bits(32)};
    lsu_req_i   = 1'b1;
    lsu_addr_i  = local_addr(12'h404);
    lsu_we_i    = 1'b0;
    lsu_be_i    = 4'hf;
    repeat (2)
    begin
      #1;
      check_value("priority gnt", 1'b0, lsu_gnt_o);
      @(negedge clk);
    end
    sys_req_i = 1'b0;
    sys_we_i  = 1'b0;
    model_write(sys_addr_i, 8, 8'hff, sys_wdata_i);
    #1;
    check_value("priority gnt after sys", 1'b1, lsu_gnt_o);
    @(negedge clk);
    lsu_req_i = 1'b0;
    #1;
    rdata = lsu_rdata_o;
    check_value("priority rvalid", 1'b1, lsu_rvalid_o);
    check_value("priority rdata", model_read32(local_addr(12'h404)), rdata);
  endtask

`endif

// File: tb/mem_region_tb.sv
// Memory region testbench
`timescale 1ns/1ps
`default_nettype none

`include "mem_region_settings.svh"

module mem_region_tb;

  import mem_region_pkg::*;

  localparam int          TEST_CYCLES = 200;
  localparam logic [31:0] EXT_XOR     = 32'h5a5a_c3c3;

  logic        clk = 1'b0;
  logic        rst_n;

  logic        lsu_req_i;
  logic [31:0] lsu_addr_i;
  logic        lsu_we_i;
  lsu_be_t     lsu_be_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_gnt_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_rdata_o;

  logic        ext_req_o;
  logic [31:0] ext_addr_o;
  logic        ext_we_o;
  lsu_be_t     ext_be_o;
  logic [31:0] ext_wdata_o;
  logic        ext_gnt_i;
  logic        ext_rvalid_i;
  logic [31:0] ext_rdata_i;

  logic        sys_req_i;
  logic [31:0] sys_addr_i;
  logic        sys_we_i;
  ram_be_t     sys_be_i;
  ram_word_u   sys_wdata_i;
  ram_word_u   sys_rdata_o;

  // byte image of the data RAM
  logic [7:0]  ref_mem [`MEM_RAM_BYTES];
  logic [31:0] lfsr_state;
  int          error_count;

  logic        ext_pend;
  logic [31:0] ext_pend_addr;

  mem_region i_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'ha300_0000;
    else
      return state >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  task automatic stop_on_error();
    error_count++;
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else
    begin
      $display("FAIL %s: expected %h, actual %h", test, exp, act);
      stop_on_error();
    end
  endtask

  // external slave, always ready, data one cycle after the grant
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ext_pend      <= 1'b0;
      ext_pend_addr <= '0;
    end
    else
    begin
      ext_pend      <= ext_req_o & ext_gnt_i;
      ext_pend_addr <= ext_addr_o;
    end
  end

  always @(negedge clk)
  begin
    ext_rvalid_i <= ext_pend;
    ext_rdata_i  <= ext_pend ? (ext_pend_addr ^ EXT_XOR) : 32'h0;
  end

  `include "mem_region_tb_tasks.svh"

  initial
  begin
    lfsr_state   = 32'h0d80_8b8b;
    error_count  = 0;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    ext_gnt_i    = 1'b1;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    sys_req_i    = 1'b0;
    sys_addr_i   = '0;
    sys_we_i     = 1'b0;
    sys_be_i     = '0;
    sys_wdata_i  = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    test_reset_state();
    test_full_word();
    test_partial_store();
    test_external();
    test_system_port();
    test_priority();

    @(negedge clk);
    if (error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    repeat (TEST_CYCLES * 20) @(posedge clk);
    $display("watchdog expired, the tests did not finish in %0d cycles", TEST_CYCLES * 20);
    stop_on_error();
  end

endmodule

`default_nettype wire

// File: logic/mem_region.sv
// Core memory region top level
`timescale 1ns/1ps
`default_nettype none

`include "mem_region_settings.svh"

module mem_region (
  input  logic                       clk,
  input  logic                       rst_n,

  // load/store port
  input  logic                       lsu_req_i,
  input  logic [31:0]                lsu_addr_i,
  input  logic                       lsu_we_i,
  input  mem_region_pkg::lsu_be_t    lsu_be_i,
  input  logic [31:0]                lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output logic [31:0]                lsu_rdata_o,

  // external data port
  output logic                       ext_req_o,
  output logic [31:0]                ext_addr_o,
  output logic                       ext_we_o,
  output mem_region_pkg::lsu_be_t    ext_be_o,
  output logic [31:0]                ext_wdata_o,
  input  logic                       ext_gnt_i,
  input  logic                       ext_rvalid_i,
  input  logic [31:0]                ext_rdata_i,

  // wide system port, byte address
  input  logic                       sys_req_i,
  input  logic [31:0]                sys_addr_i,
  input  logic                       sys_we_i,
  input  mem_region_pkg::ram_be_t    sys_be_i,
  input  mem_region_pkg::ram_word_u  sys_wdata_i,
  output mem_region_pkg::ram_word_u  sys_rdata_o
);

  import mem_region_pkg::*;

  // router to multiplexer
  logic        loc_req;
  logic [31:0] loc_addr;
  logic        loc_we;
  lsu_be_t     loc_be;
  logic [31:0] loc_wdata;
  logic        loc_gnt;
  logic        loc_rvalid;
  logic [31:0] loc_rdata;

  // multiplexer to RAM
  logic        ram_en;
  ram_addr_t   ram_addr;
  logic        ram_we;
  ram_be_t     ram_be;
  ram_word_u   ram_wdata;
  ram_word_u   ram_rdata;

  ram_addr_t   sys_word_addr;

  // low bits select a byte within the word and are dropped
  assign sys_word_addr = sys_addr_i[$clog2(`MEM_WORD_BYTES) +: $bits(ram_addr_t)];

  lsu_router i_router (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ext_req_o    ( ext_req_o    ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_we_o     ( ext_we_o     ),
    .ext_be_o     ( ext_be_o     ),
    .ext_wdata_o  ( ext_wdata_o  ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  ),
    .loc_req_o    ( loc_req      ),
    .loc_addr_o   ( loc_addr     ),
    .loc_we_o     ( loc_we       ),
    .loc_be_o     ( loc_be       ),
    .loc_wdata_o  ( loc_wdata    ),
    .loc_gnt_i    ( loc_gnt      ),
    .loc_rvalid_i ( loc_rvalid   ),
    .loc_rdata_i  ( loc_rdata    )
  );

  ram_port_mux i_mux (
    .clk          ( clk           ),
    .rst_n        ( rst_n         ),
    .sys_req_i    ( sys_req_i     ),
    .sys_addr_i   ( sys_word_addr ),
    .sys_we_i     ( sys_we_i      ),
    .sys_be_i     ( sys_be_i      ),
    .sys_wdata_i  ( sys_wdata_i   ),
    .sys_rdata_o  ( sys_rdata_o   ),
    .loc_req_i    ( loc_req       ),
    .loc_addr_i   ( loc_addr      ),
    .loc_we_i     ( loc_we        ),
    .loc_be_i     ( loc_be        ),
    .loc_wdata_i  ( loc_wdata     ),
    .loc_gnt_o    ( loc_gnt       ),
    .loc_rvalid_o ( loc_rvalid    ),
    .loc_rdata_o  ( loc_rdata     ),
    .ram_en_o     ( ram_en        ),
    .ram_addr_o   ( ram_addr      ),
    .ram_we_o     ( ram_we        ),
    .ram_be_o     ( ram_be        ),
    .ram_wdata_o  ( ram_wdata     ),
    .ram_rdata_i  ( ram_rdata     )
  );

  data_ram i_ram (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .addr_i  ( ram_addr  ),
    .we_i    ( ram_we    ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

`default_nettype wire

// File: logic/data_ram.sv
// Single-port data RAM with byte enables
`timescale 1ns/1ps
`default_nettype none

`include "mem_region_settings.svh"

module data_ram (
  input  logic                       clk,

  input  logic                       en_i,
  input  mem_region_pkg::ram_addr_t  addr_i,
  input  logic                       we_i,
  input  mem_region_pkg::ram_be_t    be_i,
  input  mem_region_pkg::ram_word_u  wdata_i,
  output mem_region_pkg::ram_word_u  rdata_o
);

  import mem_region_pkg::*;

  localparam int unsigned WORDS = `MEM_RAM_BYTES / `MEM_WORD_BYTES;

  ram_word_u mem [WORDS];

  // write byte by byte, read the old word
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < `MEM_WORD_BYTES; i++)
        begin
          if (be_i[i])
            mem[addr_i].bytes[i] <= wdata_i.bytes[i];
        end
      end

      // registered read, held while disabled
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: logic/ram_port_mux.sv
// Data RAM port multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "mem_region_settings.svh"

module ram_port_mux (
  input  logic                       clk,
  input  logic                       rst_n,

  // wide system port, always served
  input  logic                       sys_req_i,
  input  mem_region_pkg::ram_addr_t  sys_addr_i,
  input  logic                       sys_we_i,
  input  mem_region_pkg::ram_be_t    sys_be_i,
  input  mem_region_pkg::ram_word_u  sys_wdata_i,
  output mem_region_pkg::ram_word_u  sys_rdata_o,

  // local load/store port
  input  logic                       loc_req_i,
  input  logic [31:0]                loc_addr_i,
  input  logic                       loc_we_i,
  input  mem_region_pkg::lsu_be_t    loc_be_i,
  input  logic [31:0]                loc_wdata_i,
  output logic                       loc_gnt_o,
  output logic                       loc_rvalid_o,
  output logic [31:0]                loc_rdata_o,

  // single RAM port
  output logic                       ram_en_o,
  output mem_region_pkg::ram_addr_t  ram_addr_o,
  output logic                       ram_we_o,
  output mem_region_pkg::ram_be_t    ram_be_o,
  output mem_region_pkg::ram_word_u  ram_wdata_o,
  input  mem_region_pkg::ram_word_u  ram_rdata_i
);

  import mem_region_pkg::*;

  localparam int unsigned WORD_OFS = $clog2(`MEM_WORD_BYTES);

  ram_addr_t loc_word_addr;
  logic      loc_lane;
  ram_word_u loc_wdata_word;
  ram_be_t   loc_be_word;
  logic      rvalid_q;
  logic      lane_q;

  // byte address down to a word index
  assign loc_word_addr = loc_addr_i[WORD_OFS +: $bits(ram_addr_t)];

  // addr bit 2 picks the upper 32-bit lane
  assign loc_lane = loc_addr_i[2];

  // store data sits in both lanes, the enables decide which one lands
  always_comb
  begin
    loc_wdata_word.lanes[0] = loc_wdata_i;
    loc_wdata_word.lanes[1] = loc_wdata_i;

    if (loc_lane)
      loc_be_word = {loc_be_i, 4'b0000};
    else
      loc_be_word = {4'b0000, loc_be_i};
  end

  // system port has fixed priority
  assign loc_gnt_o = loc_req_i & ~sys_req_i;

  always_comb
  begin
    ram_en_o = sys_req_i | loc_gnt_o;

    if (sys_req_i)
    begin
      ram_addr_o  = sys_addr_i;
      ram_we_o    = sys_we_i;
      ram_be_o    = sys_be_i;
      ram_wdata_o = sys_wdata_i;
    end
    else
    begin
      ram_addr_o  = loc_word_addr;
      ram_we_o    = loc_we_i;
      ram_be_o    = loc_be_word;
      ram_wdata_o = loc_wdata_word;
    end
  end

  // response one cycle after the grant, lane kept for the read data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid_q <= 1'b0;
      lane_q   <= 1'b0;
    end
    else
    begin
      rvalid_q <= loc_gnt_o;
      if (loc_gnt_o)
        lane_q <= loc_lane;
    end
  end

  assign loc_rvalid_o = rvalid_q;
  assign loc_rdata_o  = ram_rdata_i.lanes[lane_q];

  // system reads see the full word
  assign sys_rdata_o = ram_rdata_i;

endmodule

`default_nettype wire

// File: logic/lsu_router.sv
// Load/store request router
`timescale 1ns/1ps
`default_nettype none

`include "mem_region_settings.svh"

module lsu_router (
  input  logic                     clk,
  input  logic                     rst_n,

  // load/store port
  input  logic                     lsu_req_i,
  input  logic [31:0]              lsu_addr_i,
  input  logic                     lsu_we_i,
  input  mem_region_pkg::lsu_be_t  lsu_be_i,
  input  logic [31:0]              lsu_wdata_i,
  output logic                     lsu_gnt_o,
  output logic                     lsu_rvalid_o,
  output logic [31:0]              lsu_rdata_o,

  // external data port
  output logic                     ext_req_o,
  output logic [31:0]              ext_addr_o,
  output logic                     ext_we_o,
  output mem_region_pkg::lsu_be_t  ext_be_o,
  output logic [31:0]              ext_wdata_o,
  input  logic                     ext_gnt_i,
  input  logic                     ext_rvalid_i,
  input  logic [31:0]              ext_rdata_i,

  // local RAM side
  output logic                     loc_req_o,
  output logic [31:0]              loc_addr_o,
  output logic                     loc_we_o,
  output mem_region_pkg::lsu_be_t  loc_be_o,
  output logic [31:0]              loc_wdata_o,
  input  logic                     loc_gnt_i,
  input  logic                     loc_rvalid_i,
  input  logic [31:0]              loc_rdata_i
);

  logic is_local;
  logic resp_ext_q;
  logic resp_ext_d;

  // window decode on the upper twelve address bits
  assign is_local = (lsu_addr_i[31:20] == `MEM_LOCAL_REGION);

  assign loc_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // payload goes to both sides, only one of them sees req
  assign loc_addr_o  = lsu_addr_i;
  assign loc_we_o    = lsu_we_i;
  assign loc_be_o    = lsu_be_i;
  assign loc_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  // grant comes from the selected side, remember it for the response
  always_comb
  begin
    lsu_gnt_o  = 1'b0;
    resp_ext_d = resp_ext_q;

    if (ext_req_o)
    begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i)
        resp_ext_d = 1'b1;
    end
    else if (loc_req_o)
    begin
      lsu_gnt_o = loc_gnt_i;
      if (loc_gnt_i)
        resp_ext_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      resp_ext_q <= 1'b0;
    else
      resp_ext_q <= resp_ext_d;
  end

  // at most one side answers in a given cycle
  assign lsu_rvalid_o = ext_rvalid_i | loc_rvalid_i;
  assign lsu_rdata_o  = resp_ext_q ? ext_rdata_i : loc_rdata_i;

endmodule

`default_nettype wire

// File: logic/mem_region_pkg.sv
// Memory region types
`default_nettype none

`include "mem_region_settings.svh"

package mem_region_pkg;

  // one RAM word, seen either as bytes or as two 32-bit lanes
  typedef union packed {
    logic [`MEM_WORD_BYTES-1:0][7:0]   bytes;
    logic [`MEM_WORD_BYTES/4-1:0][31:0] lanes;
  } ram_word_u;

  // word index into the data RAM
  typedef logic [$clog2(`MEM_RAM_BYTES / `MEM_WORD_BYTES)-1:0] ram_addr_t;

  // byte enables of a full RAM word
  typedef logic [`MEM_WORD_BYTES-1:0] ram_be_t;

  // byte enables of a 32-bit load/store word
  typedef logic [3:0] lsu_be_t;

endpackage

`default_nettype wire

// File: logic/mem_region_settings.svh
// Memory region sizes and address map
`ifndef MEM_REGION_SETTINGS_SVH
`define MEM_REGION_SETTINGS_SVH

// data RAM size in bytes
`define MEM_RAM_BYTES 4096

// bytes per RAM word, one wide system beat
`define MEM_WORD_BYTES 8

// value of addr[31:20] that selects the local RAM
`define MEM_LOCAL_REGION 12'h001

`endif
